// ==== aw_path.f ====
design/axi_pkg.sv
design/addr_map_pkg.sv
design/aw_arb_decoder.sv
design/aw_reg_slice.sv
design/aw_default_slave.sv
design/aw_path_top.sv
bench/aw_checker.sv
bench/tb_aw_path.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f aw_path.f \
  --top-module tb_aw_path \
  --Mdir obj_dir \
  -o sim_aw_path

./obj_dir/sim_aw_path | tee sim.log

grep -q "Done: no errors" sim.log

// ==== bench/tb_aw_path.sv ====
module tb_aw_path;
  timeunit 1ns;
  timeprecision 1ps;

  logic                           clk = 1'b0;
  logic                           rstn;
  logic [axi_pkg::id_bits-1:0]    id_m0, id_m1;
  logic [axi_pkg::ids_bits-1:0]   id_s0, id_s1, decerr_id;
  logic [axi_pkg::addr_bits-1:0]  addr_m0, addr_m1, addr_s0, addr_s1, decerr_addr;
  logic [axi_pkg::len_bits-1:0]   len_m0, len_m1, len_s0, len_s1;
  logic [axi_pkg::size_bits-1:0]  size_m0, size_m1, size_s0, size_s1;
  logic [axi_pkg::burst_bits-1:0] burst_m0, burst_m1, burst_s0, burst_s1;
  logic                           valid_m0, valid_m1, valid_s0, valid_s1;
  logic                           ready_m0, ready_m1;
  logic                           ready_s0 = 1'b0;
  logic                           ready_s1 = 1'b0;
  logic [15:0]                    decerr_count;
  int                             errors;
  int                             pending;
  logic [31:0]                    seed = 32'd59821;
  logic [31:0]                    ready_bits;
  int                             ready_mode = 0;
  int                             timeouts = 0;
  int                             fails_seen = 0;
  int                             tests_pass = 0;
  int                             tests_fail = 0;

  aw_path_top i_aw_path_top (.*);
  aw_checker u_checker (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] next_rand();
    seed = xorshift(seed);
    return seed;
  endfunction

  // Slave ready: 0 always high, 1 random, 2 stalled
  always begin
    @(posedge clk);
    #2;
    ready_bits = next_rand();
    ready_s0 = (ready_mode == 0) || (ready_mode == 1 && ready_bits[3]);
    ready_s1 = (ready_mode == 0) || (ready_mode == 1 && ready_bits[9]);
  end

  // Called 2 ns after a rising edge, returns at the same point after the handshake
  task automatic send_req(input int m, input int region, input int fixed_id);
    logic [31:0] r;
    logic [31:0] addr;
    logic [3:0]  id;
    logic        done;
    int          waited;
    r = next_rand();
    if (region < 0) begin
      region = int'(next_rand() % 3);
    end
    case (region)
      0:       addr = {16'h0000, r[15:0]};
      1:       addr = {16'h1000, r[15:0]};
      default: addr = {r[31:16] | 16'h2000, r[15:0]};
    endcase
    r = next_rand();
    id = (fixed_id < 0) ? r[20:17] : fixed_id[3:0];
    if (m == 0) begin
      {len_m0, size_m0, burst_m0} = r[12:0];
      id_m0 = id;
      addr_m0 = addr;
      valid_m0 = 1'b1;
    end else begin
      {len_m1, size_m1, burst_m1} = r[12:0];
      id_m1 = id;
      addr_m1 = addr;
      valid_m1 = 1'b1;
    end
    done = 1'b0;
    waited = 0;
    while (!done && waited < 300) begin
      @(negedge clk);
      done = (m == 0) ? ready_m0 : ready_m1;
      waited++;
    end
    if (!done) begin
      $display("timeout: master %0d request to 0x%0h was never accepted", m, addr);
      timeouts++;
    end
    @(posedge clk);
    #2;
    if (m == 0) begin
      valid_m0 = 1'b0;
    end else begin
      valid_m1 = 1'b0;
    end
  endtask

  task automatic stream(input int m, input int count, input int region, input int max_gap);
    int gap;
    repeat (count) begin
      gap = (max_gap > 0) ? int'(next_rand() % max_gap) : 0;
      repeat (gap) begin
        @(posedge clk);
        #2;
      end
      send_req(m, region, -1);
    end
  endtask

  task automatic finish_test(input string name);
    int waited;
    int n;
    waited = 0;
    while (pending != 0 && waited < 500) begin
      @(posedge clk);
      waited++;
    end
    if (pending != 0) begin
      $display("timeout: %0d requests never reached their slave in test %s", pending, name);
      timeouts++;
    end
    // Lets the decode error registers be checked
    @(negedge clk);
    #1;
    n = errors + timeouts - fails_seen;
    fails_seen = errors + timeouts;
    if (n == 0) begin
      tests_pass++;
      $display("test %-14s passed", name);
    end else begin
      tests_fail++;
      $display("test %-14s failed with %0d errors", name, n);
    end
    @(posedge clk);
    #2;
  endtask

  initial begin
    rstn = 1'b0;
    {valid_m0, valid_m1} = 2'b00;
    {id_m0, addr_m0, len_m0, size_m0, burst_m0} = '0;
    {id_m1, addr_m1, len_m1, size_m1, burst_m1} = '0;
    repeat (5) @(posedge clk);
    #2;
    rstn = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    finish_test("reset state");
    for (int i = 0; i < 8; i++) begin
      send_req(i % 2, (i / 2) % 2, -1);
    end
    finish_test("routing");
    send_req(0, 0, 5);
    send_req(1, 0, 5);
    send_req(0, 1, 10);
    send_req(1, 1, 10);
    finish_test("id extension");
    for (int i = 0; i < 6; i++) begin
      send_req(i % 2, 2, -1);
    end
    finish_test("unmapped");
    fork
      stream(0, 20, 0, 0);
      stream(1, 20, 0, 0);
    join
    fork
      stream(0, 20, 1, 0);
      stream(1, 20, 1, 0);
    join
    finish_test("contention");
    ready_mode = 1;
    fork
      stream(0, 40, -1, 3);
      stream(1, 40, -1, 3);
    join
    ready_mode = 2;
    fork
      stream(0, 6, -1, 0);
      stream(1, 6, -1, 0);
      begin
        repeat (40) @(posedge clk);
        ready_mode = 1;
      end
    join
    finish_test("back-pressure");
    $display("tests passed %0d failed %0d, check errors %0d, timeouts %0d",
             tests_pass, tests_fail, errors, timeouts);
    if (tests_fail == 0 && errors == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== bench/aw_checker.sv ====
module aw_checker (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic [axi_pkg::id_bits-1:0]    id_m0, id_m1,
  input  logic [axi_pkg::ids_bits-1:0]   id_s0, id_s1, decerr_id,
  input  logic [axi_pkg::addr_bits-1:0]  addr_m0, addr_m1, addr_s0, addr_s1, decerr_addr,
  input  logic [axi_pkg::len_bits-1:0]   len_m0, len_m1, len_s0, len_s1,
  input  logic [axi_pkg::size_bits-1:0]  size_m0, size_m1, size_s0, size_s1,
  input  logic [axi_pkg::burst_bits-1:0] burst_m0, burst_m1, burst_s0, burst_s1,
  input  logic                           valid_m0, valid_m1, valid_s0, valid_s1,
  input  logic                           ready_m0, ready_m1, ready_s0, ready_s1,
  input  logic [15:0]                    decerr_count,
  output int                             errors,
  output int                             pending
);
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic [axi_pkg::ids_bits-1:0]   id;
    logic [axi_pkg::addr_bits-1:0]  addr;
    logic [axi_pkg::len_bits-1:0]   len;
    logic [axi_pkg::size_bits-1:0]  size;
    logic [axi_pkg::burst_bits-1:0] burst;
  } item_t;

  item_t       q_s0[$];
  item_t       q_s1[$];
  int          dec_count;
  logic [31:0] dec_addr;
  logic [4:0]  dec_id;
  logic        dec_check;

  // Slave 0 for region 0x0000, slave 1 for 0x1000, else default slave
  function automatic int predict(input int m, input logic [3:0] id, input logic [31:0] addr,
                                 output logic [4:0] exp_id);
    exp_id = {m[0], id};
    if (addr[31:16] == 16'h0000) begin
      return 0;
    end else if (addr[31:16] == 16'h1000) begin
      return 1;
    end
    return 2;
  endfunction

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("error %s expected 0x%0h got 0x%0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic expect_req(input int m, input item_t req);
    int port;
    port = predict(m, req.id[3:0], req.addr, req.id);
    if (port == 0) begin
      q_s0.push_back(req);
    end else if (port == 1) begin
      q_s1.push_back(req);
    end else begin
      if (dec_count < 16'hffff) begin
        dec_count++;
      end
      dec_addr  = req.addr;
      dec_id    = req.id;
      dec_check = 1'b1;
    end
  endtask

  task automatic check_slave(input int s, input item_t act);
    item_t exp;
    if (s == 0) begin
      exp = q_s0.pop_front();
    end else begin
      exp = q_s1.pop_front();
    end
    compare($sformatf("id_s%0d", s), exp.id, act.id);
    compare($sformatf("addr_s%0d", s), exp.addr, act.addr);
    compare($sformatf("len_s%0d", s), exp.len, act.len);
    compare($sformatf("size_s%0d", s), exp.size, act.size);
    compare($sformatf("burst_s%0d", s), exp.burst, act.burst);
  endtask

  // Inputs change just after the rising edge, so the falling edge sees settled values
  always @(negedge clk) begin
    if (!rstn) begin
      errors    = 0;
      dec_count = 0;
      dec_check = 1'b1;
      q_s0.delete();
      q_s1.delete();
    end else begin
      if (dec_check) begin
        compare("decerr_count", dec_count, decerr_count);
        if (dec_count != 0) begin
          compare("decerr_addr", dec_addr, decerr_addr);
          compare("decerr_id", dec_id, decerr_id);
        end
        dec_check = 1'b0;
      end
      if (!valid_m0 && !valid_m1) begin
        compare("ready_m0", 0, ready_m0);
        compare("ready_m1", 0, ready_m1);
      end
      if (valid_s0 && q_s0.size() == 0) begin
        $display("slave 0 shows a request at 0x%0h that no master sent", addr_s0);
        errors++;
      end else if (valid_s0 && ready_s0) begin
        check_slave(0, {id_s0, addr_s0, len_s0, size_s0, burst_s0});
      end
      if (valid_s1 && q_s1.size() == 0) begin
        $display("slave 1 shows a request at 0x%0h that no master sent", addr_s1);
        errors++;
      end else if (valid_s1 && ready_s1) begin
        check_slave(1, {id_s1, addr_s1, len_s1, size_s1, burst_s1});
      end
      if (valid_m0 && ready_m0) begin
        expect_req(0, {1'b0, id_m0, addr_m0, len_m0, size_m0, burst_m0});
      end
      if (valid_m1 && ready_m1) begin
        expect_req(1, {1'b0, id_m1, addr_m1, len_m1, size_m1, burst_m1});
      end
    end
    pending = q_s0.size() + q_s1.size();
  end

endmodule

// ==== design/aw_path_top.sv ====
module aw_path_top (
  input  logic                           clk,
  input  logic                           rstn,
  // Master 0
  input  logic [axi_pkg::id_bits-1:0]    id_m0,
  input  logic [axi_pkg::addr_bits-1:0]  addr_m0,
  input  logic [axi_pkg::len_bits-1:0]   len_m0,
  input  logic [axi_pkg::size_bits-1:0]  size_m0,
  input  logic [axi_pkg::burst_bits-1:0] burst_m0,
  input  logic                           valid_m0,
  output logic                           ready_m0,
  // Master 1
  input  logic [axi_pkg::id_bits-1:0]    id_m1,
  input  logic [axi_pkg::addr_bits-1:0]  addr_m1,
  input  logic [axi_pkg::len_bits-1:0]   len_m1,
  input  logic [axi_pkg::size_bits-1:0]  size_m1,
  input  logic [axi_pkg::burst_bits-1:0] burst_m1,
  input  logic                           valid_m1,
  output logic                           ready_m1,
  // Slave 0
  output logic [axi_pkg::ids_bits-1:0]   id_s0,
  output logic [axi_pkg::addr_bits-1:0]  addr_s0,
  output logic [axi_pkg::len_bits-1:0]   len_s0,
  output logic [axi_pkg::size_bits-1:0]  size_s0,
  output logic [axi_pkg::burst_bits-1:0] burst_s0,
  output logic                           valid_s0,
  input  logic                           ready_s0,
  // Slave 1
  output logic [axi_pkg::ids_bits-1:0]   id_s1,
  output logic [axi_pkg::addr_bits-1:0]  addr_s1,
  output logic [axi_pkg::len_bits-1:0]   len_s1,
  output logic [axi_pkg::size_bits-1:0]  size_s1,
  output logic [axi_pkg::burst_bits-1:0] burst_s1,
  output logic                           valid_s1,
  input  logic                           ready_s1,
  // Decode errors
  output logic [15:0]                    decerr_count,
  output logic [axi_pkg::addr_bits-1:0]  decerr_addr,
  output logic [axi_pkg::ids_bits-1:0]   decerr_id
);

  // Decoder outputs toward slice 0, slice 1 and the default slave
  logic [axi_pkg::ids_bits-1:0]   id_sl0, id_sl1, id_dft;
  logic [axi_pkg::addr_bits-1:0]  addr_sl0, addr_sl1, addr_dft;
  logic [axi_pkg::len_bits-1:0]   len_sl0, len_sl1, len_dft;
  logic [axi_pkg::size_bits-1:0]  size_sl0, size_sl1, size_dft;
  logic [axi_pkg::burst_bits-1:0] burst_sl0, burst_sl1, burst_dft;
  logic                           valid_sl0, valid_sl1, valid_dft;
  logic                           ready_sl0, ready_sl1, ready_dft;

  aw_arb_decoder u_arb_dec (
    .id_s0    (id_sl0),
    .addr_s0  (addr_sl0),
    .len_s0   (len_sl0),
    .size_s0  (size_sl0),
    .burst_s0 (burst_sl0),
    .valid_s0 (valid_sl0),
    .ready_s0 (ready_sl0),
    .id_s1    (id_sl1),
    .addr_s1  (addr_sl1),
    .len_s1   (len_sl1),
    .size_s1  (size_sl1),
    .burst_s1 (burst_sl1),
    .valid_s1 (valid_sl1),
    .ready_s1 (ready_sl1),
    .id_s2    (id_dft),
    .addr_s2  (addr_dft),
    .len_s2   (len_dft),
    .size_s2  (size_dft),
    .burst_s2 (burst_dft),
    .valid_s2 (valid_dft),
    .ready_s2 (ready_dft),
    .*
  );

  aw_reg_slice u_slice_s0 (
    .id_in     (id_sl0),
    .addr_in   (addr_sl0),
    .len_in    (len_sl0),
    .size_in   (size_sl0),
    .burst_in  (burst_sl0),
    .valid_in  (valid_sl0),
    .ready_in  (ready_sl0),
    .id_out    (id_s0),
    .addr_out  (addr_s0),
    .len_out   (len_s0),
    .size_out  (size_s0),
    .burst_out (burst_s0),
    .valid_out (valid_s0),
    .ready_out (ready_s0),
    .*
  );

  aw_reg_slice u_slice_s1 (
    .id_in     (id_sl1),
    .addr_in   (addr_sl1),
    .len_in    (len_sl1),
    .size_in   (size_sl1),
    .burst_in  (burst_sl1),
    .valid_in  (valid_sl1),
    .ready_in  (ready_sl1),
    .id_out    (id_s1),
    .addr_out  (addr_s1),
    .len_out   (len_s1),
    .size_out  (size_s1),
    .burst_out (burst_s1),
    .valid_out (valid_s1),
    .ready_out (ready_s1),
    .*
  );

  aw_default_slave u_default (
    .id    (id_dft),
    .addr  (addr_dft),
    .len   (len_dft),
    .size  (size_dft),
    .burst (burst_dft),
    .valid (valid_dft),
    .ready (ready_dft),
    .*
  );

endmodule

// ==== design/aw_default_slave.sv ====
module aw_default_slave (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic [axi_pkg::ids_bits-1:0]   id,
  input  logic [axi_pkg::addr_bits-1:0]  addr,
  input  logic [axi_pkg::len_bits-1:0]   len,
  input  logic [axi_pkg::size_bits-1:0]  size,
  input  logic [axi_pkg::burst_bits-1:0] burst,
  input  logic                           valid,
  output logic                           ready,
  output logic [15:0]                    decerr_count,
  output logic [axi_pkg::addr_bits-1:0]  decerr_addr,
  output logic [axi_pkg::ids_bits-1:0]   decerr_id
);

  addr_map_pkg::aw_addr_t addr_u;
  logic                   fire;

  assign addr_u = addr;
  assign fire   = valid && ready;

  // Accepts everything once out of reset, count sticks at max
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ready        <= 1'b0;
      decerr_count <= '0;
    end else begin
      ready <= 1'b1;
      if (fire && decerr_count != 16'hffff) begin
        decerr_count <= decerr_count + 16'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      decerr_addr <= addr_u.word;
      decerr_id   <= id;
    end
  end

  // Mapped regions must have been steered elsewhere by the decoder
  a_unmapped: assert property (@(posedge clk) disable iff (!rstn)
    fire |-> addr_u.field.region != addr_map_pkg::region_s0 &&
             addr_u.field.region != addr_map_pkg::region_s1);

  // Request held while the first cycle after reset stalls it
  a_req_hold: assert property (@(posedge clk) disable iff (!rstn)
    valid && !ready |=> valid && $stable({id, addr, len, size, burst}));

endmodule

// ==== design/aw_reg_slice.sv ====
module aw_reg_slice (
  input  logic                           clk,
  input  logic                           rstn,
  // Upstream
  input  logic [axi_pkg::ids_bits-1:0]   id_in,
  input  logic [axi_pkg::addr_bits-1:0]  addr_in,
  input  logic [axi_pkg::len_bits-1:0]   len_in,
  input  logic [axi_pkg::size_bits-1:0]  size_in,
  input  logic [axi_pkg::burst_bits-1:0] burst_in,
  input  logic                           valid_in,
  output logic                           ready_in,
  // Downstream
  output logic [axi_pkg::ids_bits-1:0]   id_out,
  output logic [axi_pkg::addr_bits-1:0]  addr_out,
  output logic [axi_pkg::len_bits-1:0]   len_out,
  output logic [axi_pkg::size_bits-1:0]  size_out,
  output logic [axi_pkg::burst_bits-1:0] burst_out,
  output logic                           valid_out,
  input  logic                           ready_out
);

  logic [axi_pkg::ids_bits + axi_pkg::addr_bits + axi_pkg::len_bits +
         axi_pkg::size_bits + axi_pkg::burst_bits - 1:0] in_pay, main_pay, skid_pay;
  logic main_vld;
  logic skid_vld;
  logic in_fire;
  logic out_fire;
  logic main_load;

  assign in_pay = {id_in, addr_in, len_in, size_in, burst_in};

  // Ready comes straight off the skid flop, so no path from ready_out
  assign ready_in  = !skid_vld;
  assign in_fire   = valid_in && ready_in;
  assign out_fire  = main_vld && ready_out;
  assign main_load = !main_vld || out_fire;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      main_vld <= 1'b0;
      skid_vld <= 1'b0;
    end else if (main_load) begin
      main_vld <= skid_vld || in_fire;
      skid_vld <= 1'b0;
    end else if (in_fire) begin
      skid_vld <= 1'b1;
    end
  end

  // Skid entry is older than anything arriving now
  always_ff @(posedge clk) begin
    if (main_load) begin
      main_pay <= skid_vld ? skid_pay : in_pay;
    end
    if (in_fire && !main_load) begin
      skid_pay <= in_pay;
    end
  end

  assign {id_out, addr_out, len_out, size_out, burst_out} = main_pay;
  assign valid_out = main_vld;

  a_out_stable: assert property (@(posedge clk) disable iff (!rstn)
    valid_out && !ready_out |=> valid_out && $stable(main_pay));

endmodule

// ==== design/aw_arb_decoder.sv ====
module aw_arb_decoder (
  input  logic                           clk,
  input  logic                           rstn,
  // Master 0
  input  logic [axi_pkg::id_bits-1:0]    id_m0,
  input  logic [axi_pkg::addr_bits-1:0]  addr_m0,
  input  logic [axi_pkg::len_bits-1:0]   len_m0,
  input  logic [axi_pkg::size_bits-1:0]  size_m0,
  input  logic [axi_pkg::burst_bits-1:0] burst_m0,
  input  logic                           valid_m0,
  output logic                           ready_m0,
  // Master 1
  input  logic [axi_pkg::id_bits-1:0]    id_m1,
  input  logic [axi_pkg::addr_bits-1:0]  addr_m1,
  input  logic [axi_pkg::len_bits-1:0]   len_m1,
  input  logic [axi_pkg::size_bits-1:0]  size_m1,
  input  logic [axi_pkg::burst_bits-1:0] burst_m1,
  input  logic                           valid_m1,
  output logic                           ready_m1,
  // Slave 0
  output logic [axi_pkg::ids_bits-1:0]   id_s0,
  output logic [axi_pkg::addr_bits-1:0]  addr_s0,
  output logic [axi_pkg::len_bits-1:0]   len_s0,
  output logic [axi_pkg::size_bits-1:0]  size_s0,
  output logic [axi_pkg::burst_bits-1:0] burst_s0,
  output logic                           valid_s0,
  input  logic                           ready_s0,
  // Slave 1
  output logic [axi_pkg::ids_bits-1:0]   id_s1,
  output logic [axi_pkg::addr_bits-1:0]  addr_s1,
  output logic [axi_pkg::len_bits-1:0]   len_s1,
  output logic [axi_pkg::size_bits-1:0]  size_s1,
  output logic [axi_pkg::burst_bits-1:0] burst_s1,
  output logic                           valid_s1,
  input  logic                           ready_s1,
  // Default slave
  output logic [axi_pkg::ids_bits-1:0]   id_s2,
  output logic [axi_pkg::addr_bits-1:0]  addr_s2,
  output logic [axi_pkg::len_bits-1:0]   len_s2,
  output logic [axi_pkg::size_bits-1:0]  size_s2,
  output logic [axi_pkg::burst_bits-1:0] burst_s2,
  output logic                           valid_s2,
  input  logic                           ready_s2
);

  axi_pkg::arb_lock_t            lock_q;
  axi_pkg::arb_lock_t            lock_nxt;
  logic                          gnt_m0;
  logic                          gnt_m1;
  logic [axi_pkg::ids_bits-1:0]  id_g;
  addr_map_pkg::aw_addr_t        addr_g;
  logic [axi_pkg::len_bits-1:0]  len_g;
  logic [axi_pkg::size_bits-1:0] size_g;
  logic [axi_pkg::burst_bits-1:0] burst_g;
  logic                          valid_g;
  logic                          ready_g;
  addr_map_pkg::slave_sel_t      sel;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lock_q <= axi_pkg::lock_free;
    end else begin
      lock_q <= lock_nxt;
    end
  end

  // Fixed priority to m0 while free
  always_comb begin
    gnt_m0 = 1'b0;
    gnt_m1 = 1'b0;
    case (lock_q)
      axi_pkg::lock_m0: gnt_m0 = 1'b1;
      axi_pkg::lock_m1: gnt_m1 = 1'b1;
      default: begin
        gnt_m0 = valid_m0;
        gnt_m1 = !valid_m0 && valid_m1;
      end
    endcase
  end

  always_comb begin
    lock_nxt = axi_pkg::lock_free;
    if (valid_g && !ready_g) begin
      lock_nxt = gnt_m0 ? axi_pkg::lock_m0 : axi_pkg::lock_m1;
    end else if (gnt_m0 && valid_m1) begin
      // Hand over on completion so both masters alternate
      lock_nxt = axi_pkg::lock_m1;
    end else if (gnt_m1 && valid_m0) begin
      lock_nxt = axi_pkg::lock_m0;
    end
  end

  // Granted request, master bit above the ID
  always_comb begin
    id_g    = '0;
    addr_g  = '0;
    len_g   = '0;
    size_g  = '0;
    burst_g = '0;
    valid_g = 1'b0;
    if (gnt_m0) begin
      id_g    = {axi_pkg::master_0_id, id_m0};
      addr_g  = addr_m0;
      len_g   = len_m0;
      size_g  = size_m0;
      burst_g = burst_m0;
      valid_g = valid_m0;
    end else if (gnt_m1) begin
      id_g    = {axi_pkg::master_1_id, id_m1};
      addr_g  = addr_m1;
      len_g   = len_m1;
      size_g  = size_m1;
      burst_g = burst_m1;
      valid_g = valid_m1;
    end
  end

  always_comb begin
    if (addr_g.field.region == addr_map_pkg::region_s0) begin
      sel = addr_map_pkg::sel_s0;
    end else if (addr_g.field.region == addr_map_pkg::region_s1) begin
      sel = addr_map_pkg::sel_s1;
    end else begin
      sel = addr_map_pkg::sel_default;
    end
  end

  // Unselected ports stay at zero
  assign {id_s0, addr_s0, len_s0, size_s0, burst_s0, valid_s0} =
    (sel == addr_map_pkg::sel_s0) ?
    {id_g, addr_g.word, len_g, size_g, burst_g, valid_g} : '0;
  assign {id_s1, addr_s1, len_s1, size_s1, burst_s1, valid_s1} =
    (sel == addr_map_pkg::sel_s1) ?
    {id_g, addr_g.word, len_g, size_g, burst_g, valid_g} : '0;
  assign {id_s2, addr_s2, len_s2, size_s2, burst_s2, valid_s2} =
    (sel == addr_map_pkg::sel_default) ?
    {id_g, addr_g.word, len_g, size_g, burst_g, valid_g} : '0;

  always_comb begin
    case (sel)
      addr_map_pkg::sel_s0: ready_g = ready_s0;
      addr_map_pkg::sel_s1: ready_g = ready_s1;
      default:              ready_g = ready_s2;
    endcase
  end

  assign ready_m0 = gnt_m0 && ready_g;
  assign ready_m1 = gnt_m1 && ready_g;

  // Stalled master keeps its request up and stable
  a_hold_m0: assert property (@(posedge clk) disable iff (!rstn)
    gnt_m0 && valid_m0 && !ready_m0 |=>
    valid_m0 && $stable({id_m0, addr_m0, len_m0, size_m0, burst_m0}));
  a_hold_m1: assert property (@(posedge clk) disable iff (!rstn)
    gnt_m1 && valid_m1 && !ready_m1 |=>
    valid_m1 && $stable({id_m1, addr_m1, len_m1, size_m1, burst_m1}));

  a_one_slave: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0({valid_s0, valid_s1, valid_s2}));

endmodule

// ==== design/addr_map_pkg.sv ====
package addr_map_pkg;

  // Upper address bits pick the region
  localparam int region_bits = 16;

  localparam logic [region_bits-1:0] region_s0 = 16'h0000;
  localparam logic [region_bits-1:0] region_s1 = 16'h1000;

  typedef struct packed {
    logic [region_bits-1:0]                    region;
    logic [axi_pkg::addr_bits-region_bits-1:0] offset;
  } aw_region_t;

  // One address word, seen raw or split into region and offset
  typedef union packed {
    logic [axi_pkg::addr_bits-1:0] word;
    aw_region_t                    field;
  } aw_addr_t;

  // Routing target
  typedef enum logic [1:0] {
    sel_s0      = 2'd0,
    sel_s1      = 2'd1,
    sel_default = 2'd2
  } slave_sel_t;

endpackage

// ==== design/axi_pkg.sv ====
package axi_pkg;

  // Master side ID and the widened slave side ID
  localparam int id_bits = 4;
  localparam int ids_bits = id_bits + 1;

  // Write-address field widths
  localparam int addr_bits = 32;
  localparam int len_bits = 8;
  localparam int size_bits = 3;
  localparam int burst_bits = 2;

  // Prefix above the master ID, used later to route the write response back
  localparam logic master_0_id = 1'b0;
  localparam logic master_1_id = 1'b1;

  // Arbiter grant lock
  typedef enum logic [1:0] {
    lock_free = 2'd0,
    lock_m0   = 2'd1,
    lock_m1   = 2'd2
  } arb_lock_t;

endpackage
